/* hdl/mbMemory.sv */
`timescale 1ns/1ps
`include "mbMem_consts.svh"

module mbMemory (
  input  logic                       SBUS,
  input  logic                       rst,
  input  logic [`NUM_PHASES-1:0]     start,
  input  sbusPkg::rqMask             rq,
  input  sbusPkg::sbusAdr            adr,
  input  logic                       loadEn,
  input  memPkg::memIndex            loadAdr,
  input  sbusPkg::sbusWord           loadData,
  output logic [`NUM_PHASES-1:0]     ackn,
  output logic [`NUM_PHASES-1:0]     dataValid,
  output sbusPkg::sbusWord           d,
  output logic                       dataPar,
  output logic                       nxm
);

  import sbusPkg::*;
  import memPkg::*;

  // Latched request
  logic [`NUM_PHASES-1:0] phStart;
  rqMask                  phRq;
  sbusAdr                 phAdr;

  // Read ports and returned words
  logic    [`NUM_PHASES-1:0] rdEn;
  memIndex [`NUM_PHASES-1:0] rdIndex;
  sbusWord [`NUM_PHASES-1:0] rdData;
  logic    [`NUM_PHASES-1:0] wordValid;

  sbusRequestLatch i_sbusRequestLatch (
    .SBUS    (SBUS),
    .rst     (rst),
    .start   (start),
    .rq      (rq),
    .adr     (adr),
    .phStart (phStart),
    .phRq    (phRq),
    .phAdr   (phAdr),
    .nxm     (nxm)
  );

  // Phase A is index 0, phase B index 1
  for (genvar p = 0; p < `NUM_PHASES; p++) begin : g_phase
    memPhase i_memPhase (
      .SBUS      (SBUS),
      .rst       (rst),
      .phStart   (phStart[p]),
      .phRq      (phRq),
      .phAdr     (phAdr),
      .ackn      (ackn[p]),
      .rdEn      (rdEn[p]),
      .rdIndex   (rdIndex[p]),
      .wordValid (wordValid[p])
    );
  end

  memStore i_memStore (
    .SBUS     (SBUS),
    .loadEn   (loadEn),
    .loadAdr  (loadAdr),
    .loadData (loadData),
    .rdEn     (rdEn),
    .rdIndex  (rdIndex),
    .rdData   (rdData)
  );

  sbusReturnMerge i_sbusReturnMerge (
    .SBUS      (SBUS),
    .rst       (rst),
    .wordValid (wordValid),
    .rdData    (rdData),
    .d         (d),
    .dataPar   (dataPar),
    .dataValid (dataValid)
  );

endmodule

/* hdl/memPhase.sv */
`timescale 1ns/1ps
`include "mbMem_consts.svh"

module memPhase (
  input  logic              SBUS,
  input  logic              rst,
  input  logic              phStart,
  input  sbusPkg::rqMask    phRq,
  input  sbusPkg::sbusAdr   phAdr,
  output logic              ackn,
  output logic              rdEn,
  output memPkg::memIndex   rdIndex,
  output logic              wordValid
);

  import sbusPkg::*;
  import memPkg::*;

  phaseState state;
  phaseState next;

  // Slots not yet acknowledged
  // Bit 0 is the slot being worked on
  rqMask toAck;

  // Quadword base with its low two bits cleared
  memIndex base;

  // Current word offset, advanced mod 4 after each read
  wordOffset wo;

  // State register
  always_ff @(posedge SBUS) begin
    if (rst) begin
      state <= phIdle;
    end else begin
      state <= next;
    end
  end

  // Next state
  always_comb begin
    next = state;
    case (state)
      phIdle: begin
        // A start while busy never reaches this branch
        if (phStart) begin
          next = phRq[0] ? phAck : phShift;
        end
      end
      phAck: begin
        next = phRead;
      end
      phRead: begin
        next = phShift;
      end
      phShift: begin
        if (toAck[1]) begin
          next = phAck;
        end else if (toAck[`RQ_WIDTH-1:1] == '0) begin
          next = phWaitIdle;
        end
        // Otherwise keep shifting clear slots out
      end
      phWaitIdle: begin
        next = phIdle;
      end
      default: begin
        next = phIdle;
      end
    endcase
  end

  // Remaining slot mask
  always_ff @(posedge SBUS) begin
    if (rst) begin
      toAck <= '0;
    end else if (state == phIdle && phStart) begin
      toAck <= phRq;
    end else if (state == phShift) begin
      toAck <= toAck >> 1;
    end
  end

  // Quadword base and word offset
  always_ff @(posedge SBUS) begin
    if (state == phIdle && phStart) begin
      base <= memIndex'({phAdr[`MEM_ADR_BITS-1:2], 2'b00});
      wo   <= phAdr[1:0];
    end else if (state == phRead) begin
      // Clear slots do not move the offset
      wo <= wo + 2'd1;
    end
  end

  // Acknowledge and read issue together
  assign ackn    = (state == phAck);
  assign rdEn    = (state == phAck);
  assign rdIndex = {base[`MEM_ADR_BITS-1:2], wo};

  // Store data is on rdData during phRead
  assign wordValid = (state == phRead);

endmodule

/* hdl/memPkg.sv */
`include "mbMem_consts.svh"

// Types used inside the core memory
package memPkg;

  // Index into the storage array
  typedef logic [`MEM_ADR_BITS-1:0] memIndex;

  // Word position within a quadword
  typedef logic [1:0] wordOffset;

  // Phase controller states
  typedef enum logic [2:0] {
    phIdle,
    phAck,
    phRead,
    phShift,
    phWaitIdle
  } phaseState;

endpackage

/* hdl/memStore.sv */
`timescale 1ns/1ps
`include "mbMem_consts.svh"

module memStore (
  input  logic                                  SBUS,
  input  logic                                  loadEn,
  input  memPkg::memIndex                       loadAdr,
  input  sbusPkg::sbusWord                      loadData,
  input  logic            [`NUM_PHASES-1:0]     rdEn,
  input  memPkg::memIndex [`NUM_PHASES-1:0]     rdIndex,
  output sbusPkg::sbusWord [`NUM_PHASES-1:0]    rdData
);

  import sbusPkg::*;

  // Core array
  // Contents survive reset like real cores
  sbusWord mem [`MEM_SIZE];

  // Load port
  always_ff @(posedge SBUS) begin
    if (loadEn) begin
      mem[loadAdr] <= loadData;
    end
  end

  // One synchronous read port per phase
  // Data is ready the cycle after rdEn
  always_ff @(posedge SBUS) begin
    for (int p = 0; p < `NUM_PHASES; p++) begin
      if (rdEn[p]) begin
        rdData[p] <= mem[rdIndex[p]];
      end
    end
  end

endmodule

/* hdl/sbusPkg.sv */
`include "mbMem_consts.svh"

// Types seen on the SBUS side of the memory
package sbusPkg;

  // One data word as carried on the D lines
  typedef logic [`WORD_BITS-1:0] sbusWord;

  // Word address
  // Bit 0 here is KL10 address bit 35
  typedef logic [`SBUS_ADR_BITS-1:0] sbusAdr;

  // Quadword request mask
  // Bit 0 is the first word slot
  typedef logic [`RQ_WIDTH-1:0] rqMask;

endpackage

/* hdl/sbusRequestLatch.sv */
`timescale 1ns/1ps
`include "mbMem_consts.svh"

module sbusRequestLatch (
  input  logic                       SBUS,
  input  logic                       rst,
  input  logic [`NUM_PHASES-1:0]     start,
  input  sbusPkg::rqMask             rq,
  input  sbusPkg::sbusAdr            adr,
  output logic [`NUM_PHASES-1:0]     phStart,
  output sbusPkg::rqMask             phRq,
  output sbusPkg::sbusAdr            phAdr,
  output logic                       nxm
);

  import sbusPkg::*;

  // First word address past the end of the array
  localparam sbusAdr memTop = sbusAdr'(`MEM_SIZE);

  logic anyStart;
  logic inRange;

  assign anyStart = |start;

  // Screen addresses beyond the installed memory
  assign inRange = (adr < memTop);

  // SBUS signals are sampled on the edge after they are driven
  // Start goes only to the phase named by its own bit
  always_ff @(posedge SBUS) begin
    if (rst) begin
      phStart <= '0;
      nxm     <= 1'b0;
    end else begin
      phStart <= inRange ? start : '0;
      // Nonexistent memory gets no acknowledge, just this pulse
      nxm     <= anyStart && !inRange;
    end
  end

  // Request payload shared by both phases
  always_ff @(posedge SBUS) begin
    if (anyStart) begin
      phRq  <= rq;
      phAdr <= adr;
    end
  end

endmodule

/* hdl/sbusReturnMerge.sv */
`timescale 1ns/1ps
`include "mbMem_consts.svh"

module sbusReturnMerge (
  input  logic                                 SBUS,
  input  logic                                 rst,
  input  logic             [`NUM_PHASES-1:0]   wordValid,
  input  sbusPkg::sbusWord [`NUM_PHASES-1:0]   rdData,
  output sbusPkg::sbusWord                     d,
  output logic                                 dataPar,
  output logic             [`NUM_PHASES-1:0]   dataValid
);

  import sbusPkg::*;

  // Word selected for the bus this cycle
  sbusWord selWord;

  // One-hot owner of the selected word
  logic [`NUM_PHASES-1:0] selTag;

  // Phase B word parked on a collision
  logic    holdValid;
  sbusWord holdWord;
  logic    holdLoad;

  // Held word goes out first
  // Phase A wins a fresh collision
  always_comb begin
    selWord = '0;
    selTag  = '0;
    if (holdValid) begin
      selWord   = holdWord;
      selTag[1] = 1'b1;
    end else if (wordValid[0]) begin
      selWord   = rdData[0];
      selTag[0] = 1'b1;
    end else if (wordValid[1]) begin
      selWord   = rdData[1];
      selTag[1] = 1'b1;
    end
  end

  // Phase B lost the bus this cycle
  assign holdLoad = wordValid[1] && (holdValid || wordValid[0]);

  // One entry is enough since a phase's words are three cycles apart
  always_ff @(posedge SBUS) begin
    if (rst) begin
      holdValid <= 1'b0;
    end else begin
      holdValid <= holdLoad;
    end
  end

  always_ff @(posedge SBUS) begin
    if (holdLoad) begin
      holdWord <= rdData[1];
    end
  end

  // Valid strobes, one cycle per word
  always_ff @(posedge SBUS) begin
    if (rst) begin
      dataValid <= '0;
    end else begin
      dataValid <= selTag;
    end
  end

  // Returned word with its parity bit
  always_ff @(posedge SBUS) begin
    d       <= selWord;
    dataPar <= ^selWord;
  end

endmodule

/* include/mbMem_consts.svh */
`ifndef MBMEM_CONSTS_SVH
`define MBMEM_CONSTS_SVH

// Core memory size in 36-bit words
`define MEM_SIZE 262144

// Width of the storage array index
`define MEM_ADR_BITS 18

// SBUS word address, KL10 address bits 12 to 35
`define SBUS_ADR_BITS 24

// Width of one data word
`define WORD_BITS 36

// Independent memory phases A and B
`define NUM_PHASES 2

// Words in a quadword request
`define RQ_WIDTH 4

`endif

/* tb.f */
+incdir+include
hdl/sbusPkg.sv
hdl/memPkg.sv
hdl/memStore.sv
hdl/sbusRequestLatch.sv
hdl/memPhase.sv
hdl/sbusReturnMerge.sv
hdl/mbMemory.sv
tests/mbMemoryTb.sv

/* tests/mbMemoryTb.sv */
`timescale 1ns/1ps
`include "mbMem_consts.svh"

module mbMemoryTb;

  import sbusPkg::*;
  import memPkg::*;

  // Cycles one request may take before its words count as missing
  localparam int reqWait = 40;

  // Reference copy covers the low words the patterns touch
  localparam int refSize = 512;

  // Random fill region
  localparam int randBase  = 'h100;
  localparam int randCount = 16;

  localparam string patternPath = "tests/mbMemory_patterns.txt";

  logic                   SBUS;
  logic                   rst;
  logic [`NUM_PHASES-1:0] start;
  rqMask                  rq;
  sbusAdr                 adr;
  logic                   loadEn;
  memIndex                loadAdr;
  sbusWord                loadData;
  logic [`NUM_PHASES-1:0] ackn;
  logic [`NUM_PHASES-1:0] dataValid;
  sbusWord                d;
  logic                   dataPar;
  logic                   nxm;

  // Reference memory model
  sbusWord refMem [0:refSize-1];

  // Expected word indices, one queue per phase, in return order
  memIndex expQ0 [$];
  memIndex expQ1 [$];

  // Acknowledged words still waiting for dataValid, oldest first
  int ackPhase [$];
  int ackCycle [$];

  int ackCount [`NUM_PHASES];
  int nxmCount;

  int wordErrors   = 0;
  int parityErrors = 0;
  int phaseErrors  = 0;
  int otherErrors  = 0;
  int cycles       = 0;
  int cycleLimit   = 0;

  // Request read from the file, sent once its expect lines are in
  logic                   pending = 1'b0;
  logic [`NUM_PHASES-1:0] pendStart;
  sbusAdr                 pendAdr;
  rqMask                  pendRq;

  initial SBUS = 1'b0;
  always #50 SBUS = ~SBUS;

  mbMemory i_mbMemory (
    .SBUS      (SBUS),
    .rst       (rst),
    .start     (start),
    .rq        (rq),
    .adr       (adr),
    .loadEn    (loadEn),
    .loadAdr   (loadAdr),
    .loadData  (loadData),
    .ackn      (ackn),
    .dataValid (dataValid),
    .d         (d),
    .dataPar   (dataPar),
    .nxm       (nxm)
  );

  // Run limit from the number of request lines
  always @(posedge SBUS) begin
    cycles = cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic checkWord(input sbusWord expected, input sbusWord actual);
    if (actual !== expected) begin
      wordErrors++;
      $display("FAILED %0t d expected %h actual %h", $time, expected, actual);
    end
  endtask

  task automatic checkParity(input logic expected, input logic actual);
    if (actual !== expected) begin
      parityErrors++;
      $display("FAILED %0t dataPar expected %b actual %b", $time, expected, actual);
    end
  endtask

  task automatic checkPhase(input logic [`NUM_PHASES-1:0] expected,
                            input logic [`NUM_PHASES-1:0] actual);
    if (actual !== expected) begin
      phaseErrors++;
      $display("FAILED %0t dataValid expected %b actual %b", $time, expected, actual);
    end
  endtask

  task automatic reportProblem(input string msg);
    otherErrors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // Bus outputs must rest low around reset
  task automatic checkQuiet();
    if (ackn !== '0 || dataValid !== '0 || nxm !== 1'b0) begin
      reportProblem("ackn, dataValid or nxm not low around reset");
    end
  endtask

  // Write one word through the load port and into the model
  task automatic loadWord(input memIndex idx, input sbusWord w);
    @(posedge SBUS);
    #5;
    loadEn   = 1'b1;
    loadAdr  = idx;
    loadData = w;
    refMem[idx] = w;
    @(posedge SBUS);
    #5;
    loadEn = 1'b0;
  endtask

  // Sampled at the falling edge, away from DUT updates
  task automatic observeCycle();
    int p;
    int lat;
    memIndex idx;
    logic [`NUM_PHASES-1:0] tag;
    for (int i = 0; i < `NUM_PHASES; i++) begin
      if (ackn[i]) begin
        ackPhase.push_back(i);
        ackCycle.push_back(cycles);
        ackCount[i]++;
      end
    end
    if (nxm) begin
      nxmCount++;
    end
    if (dataValid != '0) begin
      if (ackPhase.size() == 0) begin
        reportProblem("word returned without an acknowledge");
      end else begin
        p   = ackPhase.pop_front();
        lat = cycles - ackCycle.pop_front();
        tag = '0;
        tag[p] = 1'b1;
        // Phase A wins a collision, so returns keep acknowledge order
        checkPhase(tag, dataValid);
        if (lat < 2 || lat > 3) begin
          reportProblem($sformatf("ackn to dataValid took %0d cycles", lat));
        end
        if (p == 0 && expQ0.size() > 0) begin
          idx = expQ0.pop_front();
        end else if (p == 1 && expQ1.size() > 0) begin
          idx = expQ1.pop_front();
        end else begin
          reportProblem($sformatf("more words than expected on phase %0d", p));
          idx = '0;
        end
        checkWord(refMem[idx], d);
        // Parity is the XOR of all 36 bits
        checkParity(^refMem[idx], dataPar);
      end
    end
  endtask

  // Send the pending request and watch every response
  task automatic runPending();
    int waitCycles;
    int wantAck [`NUM_PHASES];
    logic inRange;
    if (pending) begin
      pending = 1'b0;
      inRange = (pendAdr < `MEM_SIZE);
      // One acknowledge per set mask bit, none beyond the memory
      for (int i = 0; i < `NUM_PHASES; i++) begin
        wantAck[i]  = (pendStart[i] && inRange) ? $countones(pendRq) : 0;
        ackCount[i] = 0;
      end
      if (expQ0.size() != wantAck[0] || expQ1.size() != wantAck[1]) begin
        reportProblem($sformatf("pattern words for adr %h do not match the mask", pendAdr));
      end
      nxmCount = 0;
      @(posedge SBUS);
      #5;
      start = pendStart;
      rq    = pendRq;
      adr   = pendAdr;
      @(posedge SBUS);
      #5;
      start = '0;
      waitCycles = 0;
      while ((expQ0.size() > 0 || expQ1.size() > 0 || (!inRange && nxmCount == 0))
             && waitCycles < reqWait) begin
        @(negedge SBUS);
        observeCycle();
        waitCycles++;
      end
      // Trailing cycles catch stray acknowledges, words and nxm
      repeat (4) begin
        @(negedge SBUS);
        observeCycle();
      end
      if (expQ0.size() > 0 || expQ1.size() > 0) begin
        reportProblem($sformatf("words missing for request at adr %h", pendAdr));
      end
      for (int i = 0; i < `NUM_PHASES; i++) begin
        if (ackCount[i] != wantAck[i]) begin
          reportProblem($sformatf("phase %0d gave %0d ackn pulses, %0d wanted",
                                  i, ackCount[i], wantAck[i]));
        end
      end
      if (inRange && nxmCount != 0) begin
        reportProblem($sformatf("unexpected nxm for adr %h", pendAdr));
      end
      if (!inRange && nxmCount != 1) begin
        reportProblem($sformatf("nxm for adr %h missing or not one cycle", pendAdr));
      end
      if (ackPhase.size() != 0) begin
        reportProblem("acknowledged words never returned");
      end
      expQ0.delete();
      expQ1.delete();
      ackPhase.delete();
      ackCycle.delete();
    end
  endtask

  initial begin
    int fd;
    int nReq;
    int p;
    string line;
    memIndex idx;
    sbusWord w;
    logic [`NUM_PHASES-1:0] st;
    sbusAdr a;
    rqMask m;
    rst      = 1'b1;
    start    = '0;
    rq       = '0;
    adr      = '0;
    loadEn   = 1'b0;
    loadAdr  = '0;
    loadData = '0;
    void'($urandom(17));

    // Count request lines to size the run limit
    nReq = 0;
    fd = $fopen(patternPath, "r");
    if (fd == 0) begin
      $display("Cannot open %s", patternPath);
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) == "R") begin
          nReq++;
        end
      end
      $fclose(fd);
      cycleLimit = 12 * nReq + 200;

      // Reset for 4 rising edges, outputs checked during and after
      @(posedge SBUS);
      repeat (3) begin
        @(negedge SBUS);
        checkQuiet();
      end
      @(posedge SBUS);
      #5;
      rst = 1'b0;
      repeat (2) begin
        @(negedge SBUS);
        checkQuiet();
      end

      // Random words, kept in the model as well
      for (int i = 0; i < randCount; i++) begin
        w = sbusWord'({$urandom(), $urandom()});
        loadWord(memIndex'(randBase + i), w);
      end

      fd = $fopen(patternPath, "r");
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0) begin
          case (line.getc(0))
            "L": begin
              runPending();
              if ($sscanf(line, "L %h %h", idx, w) == 2) begin
                loadWord(idx, w);
              end
            end
            "R": begin
              runPending();
              if ($sscanf(line, "R %h %h %h", st, a, m) == 3) begin
                pending   = 1'b1;
                pendStart = st;
                pendAdr   = a;
                pendRq    = m;
              end
            end
            "E": begin
              if ($sscanf(line, "E %h %h", p, idx) == 2) begin
                if (p == 0) begin
                  expQ0.push_back(idx);
                end else begin
                  expQ1.push_back(idx);
                end
              end
            end
            default: begin
            end
          endcase
        end
      end
      runPending();
      $fclose(fd);

      $display("Errors: word %0d, parity %0d, phase %0d, other %0d",
               wordErrors, parityErrors, phaseErrors, otherErrors);
      if (wordErrors + parityErrors + phaseErrors + otherErrors == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

/* tests/mbMemory_patterns.txt */
# L index word : load a word, hex | R start adr mask : request, start 1=A 2=B 3=both
# E phase index : next word expected on phase 0=A or 1=B, in order
L 040 0A0000040
L 041 0A0000041
L 042 0A0000042
L 043 0A0000043
L 080 5F0F0F080
L 081 5F0F0F081
L 082 5F0F0F082
L 083 5F0F0F083
L 0C0 FFFFFFFFF
L 0C1 000000000
L 0C2 800000001
L 0C3 123456789
# Full quadword on phase A from offset 2
R 1 000042 F
E 0 042
E 0 043
E 0 040
E 0 041
# Mask 1010 from offset 1, clear slots do not advance
R 1 000081 A
E 0 081
E 0 082
# Parity on all-ones, all-zero and fixed words
R 1 0000C0 F
E 0 0C0
E 0 0C1
E 0 0C2
E 0 0C3
# Parity on random words through phase B
R 2 000104 F
E 1 104
E 1 105
E 1 106
E 1 107
# Both phases in the same cycle
R 3 00010E F
E 0 10E
E 0 10F
E 0 10C
E 0 10D
E 1 10E
E 1 10F
E 1 10C
E 1 10D
# Both phases, mask 0101 from offset 3
R 3 000043 5
E 0 043
E 0 040
E 1 043
E 1 040
# Empty mask
R 1 0000C1 0
# Nonexistent memory, then a valid request
R 1 040000 F
R 2 FFFFFF 3
R 2 000080 1
E 1 080
